// File: include/analogizer_cfg.svh
/* Fixed widths, colour matrix weights and pipeline depth of the analog video path.
   Included by every RTL file that sizes a port or a product, and by the testbench */
`ifndef ANALOGIZER_CFG_SVH
`define ANALOGIZER_CFG_SVH

`define AZ_COLOR_W 8 // Core colour, bits per channel
`define AZ_DAC_W 6 // DAC input bits per channel
`define AZ_PIPE_LAT 5 // Input sample to bank pins, video_clk cycles

// Luma weights, 8 fractional bits, sum is 256
`define AZ_Y_KR 10'sd77
`define AZ_Y_KG 10'sd150
`define AZ_Y_KB 10'sd29

// Pb weights, sum is zero
`define AZ_PB_KR (-10'sd43)
`define AZ_PB_KG (-10'sd85)
`define AZ_PB_KB 10'sd128

// Pr weights, sum is zero
`define AZ_PR_KR 10'sd128
`define AZ_PR_KG (-10'sd107)
`define AZ_PR_KB (-10'sd21)

// Mid-scale offset for the colour difference channels
`define AZ_CHROMA_OFS 10'sd128

`endif

// File: design/analogizer_pkg.sv
/* Types shared along the analog video path.
   Pixel bundle between stages, DAC sample at the pins, mode and scanline codes */
`default_nettype none

`include "analogizer_cfg.svh"

package analogizer_pkg;

	// One pixel with its timing, 28 bits, syncs active low
	typedef struct packed {
		logic [`AZ_COLOR_W-1:0] r; // R, or Pr after the matrix
		logic [`AZ_COLOR_W-1:0] g; // G, or Y
		logic [`AZ_COLOR_W-1:0] b; // B, or Pb
		logic hsync_n;
		logic vsync_n;
		logic csync_n;
		logic blank_n; // Low outside active video
	} video_pix_t;

	// One DAC sample as it reaches the connector, 21 bits
	typedef struct packed {
		logic [`AZ_DAC_W-1:0] r;
		logic [`AZ_DAC_W-1:0] g;
		logic [`AZ_DAC_W-1:0] b;
		logic hs_pin; // VGA H pin, also carries csync in RGBS
		logic vs_pin; // VGA V pin or DAC sync input
		logic blank_n_pin; // DAC blank input
	} dac_word_t;

	// Output standard selected by the core
	typedef enum logic [3:0] {
		MODE_RGBS = 4'd0, // Csync on H pin
		MODE_RGSB = 4'd1, // Sync on green through DAC sync
		MODE_YPBPR = 4'd2, // Component, sync on Y
		MODE_RGBHV_SL = 4'd5 // Separate syncs with scanlines
	} video_mode_e;

	// Odd line attenuation
	typedef enum logic [1:0] {
		SL_OFF = 2'd0,
		SL_25 = 2'd1,
		SL_50 = 2'd2,
		SL_75 = 2'd3
	} scanline_e;

endpackage

`default_nettype wire

// File: design/video_in_stage.sv
/* Front of the video path. Samples the core's loose colour and sync signals
   into one pixel bundle and forces black wherever blank_n is low */
`timescale 1ns/1ps
`default_nettype none

`include "analogizer_cfg.svh"

module video_in_stage
	import analogizer_pkg::*;
(
	input logic i_reset,
	input logic video_clk,
	input logic [`AZ_COLOR_W-1:0] i_r,
	input logic [`AZ_COLOR_W-1:0] i_g,
	input logic [`AZ_COLOR_W-1:0] i_b,
	input logic i_hsync_n,
	input logic i_vsync_n,
	input logic i_csync_n,
	input logic i_blank_n,
	output video_pix_t o_pix
);

	// Colour mask, some cores leave data on the bus during blanking
	logic [`AZ_COLOR_W-1:0] blank_mask;
	video_pix_t pix_nxt;

	assign blank_mask = {`AZ_COLOR_W{i_blank_n}};

	always_comb begin
		pix_nxt.r = i_r & blank_mask;
		pix_nxt.g = i_g & blank_mask;
		pix_nxt.b = i_b & blank_mask;
		// Timing passes untouched
		pix_nxt.hsync_n = i_hsync_n;
		pix_nxt.vsync_n = i_vsync_n;
		pix_nxt.csync_n = i_csync_n;
		pix_nxt.blank_n = i_blank_n;
	end

	// Single register stage, one pixel per clock
	always_ff @(posedge video_clk) begin
		if (i_reset) begin
			o_pix <= '0; // Whole bundle cleared, syncs included
		end else begin
			o_pix <= pix_nxt;
		end
	end

endmodule

`default_nettype wire

// File: design/ypbpr_matrix.sv
/* RGB to YPbPr colour matrix, three register stages deep.
   Products, then channel sums, then shift, offset and clamp.
   Output r carries Pr, g carries Y, b carries Pb; timing rides alongside */
`timescale 1ns/1ps
`default_nettype none

`include "analogizer_cfg.svh"

module ypbpr_matrix
	import analogizer_pkg::*;
(
	input logic video_clk,
	input logic i_reset,
	input video_pix_t i_pix,
	output video_pix_t o_pix
);

	localparam int unsigned FRAC_BITS = 8; // Weights are scaled by 256

	// Index 0 is the R term, 1 the G term, 2 the B term
	logic signed [18:0] y_prod [3];
	logic signed [18:0] pb_prod [3];
	logic signed [18:0] pr_prod [3];
	logic signed [20:0] y_sum, pb_sum, pr_sum;
	logic signed [20:0] y_sh, pb_ofs, pr_ofs;
	logic [3:0] sync_q [2]; // {hsync_n, vsync_n, csync_n, blank_n}

	// Unsigned colour times signed weight
	function automatic logic signed [18:0] mul(input logic [`AZ_COLOR_W-1:0] c,
			input logic signed [9:0] k);
		mul = $signed({1'b0, c}) * k;
	endfunction

	function automatic logic [`AZ_COLOR_W-1:0] clamp8(input logic signed [20:0] v);
		if (v < 0) begin
			clamp8 = '0;
		end else if (v > 21'sd255) begin
			clamp8 = '1;
		end else begin
			clamp8 = v[`AZ_COLOR_W-1:0];
		end
	endfunction

	// Stage three arithmetic, arithmetic shift keeps the sign
	assign y_sh = y_sum >>> FRAC_BITS; // Always 0..255, weights sum to 256
	assign pb_ofs = (pb_sum >>> FRAC_BITS) + `AZ_CHROMA_OFS;
	assign pr_ofs = (pr_sum >>> FRAC_BITS) + `AZ_CHROMA_OFS;

	always_ff @(posedge video_clk) begin
		if (i_reset) begin
			y_prod <= '{default: '0};
			pb_prod <= '{default: '0};
			pr_prod <= '{default: '0};
			y_sum <= '0;
			pb_sum <= '0;
			pr_sum <= '0;
			sync_q <= '{default: '0};
			o_pix <= '0;
		end else begin
			// Stage 1, nine products
			y_prod[0] <= mul(i_pix.r, `AZ_Y_KR);
			y_prod[1] <= mul(i_pix.g, `AZ_Y_KG);
			y_prod[2] <= mul(i_pix.b, `AZ_Y_KB);
			pb_prod[0] <= mul(i_pix.r, `AZ_PB_KR);
			pb_prod[1] <= mul(i_pix.g, `AZ_PB_KG);
			pb_prod[2] <= mul(i_pix.b, `AZ_PB_KB);
			pr_prod[0] <= mul(i_pix.r, `AZ_PR_KR);
			pr_prod[1] <= mul(i_pix.g, `AZ_PR_KG);
			pr_prod[2] <= mul(i_pix.b, `AZ_PR_KB);
			sync_q[0] <= {i_pix.hsync_n, i_pix.vsync_n, i_pix.csync_n, i_pix.blank_n};
			// Stage 2, per channel sums
			y_sum <= y_prod[0] + y_prod[1] + y_prod[2];
			pb_sum <= pb_prod[0] + pb_prod[1] + pb_prod[2];
			pr_sum <= pr_prod[0] + pr_prod[1] + pr_prod[2];
			sync_q[1] <= sync_q[0];
			// Stage 3, scale back to 8 bits
			o_pix.r <= clamp8(pr_ofs);
			o_pix.g <= y_sh[`AZ_COLOR_W-1:0];
			o_pix.b <= clamp8(pb_ofs);
			o_pix.hsync_n <= sync_q[1][3];
			o_pix.vsync_n <= sync_q[1][2];
			o_pix.csync_n <= sync_q[1][1];
			o_pix.blank_n <= sync_q[1][0];
		end
	end

endmodule

`default_nettype wire

// File: design/scanline_dimmer.sv
/* Scanline effect for the RGBHV mode. Tracks odd and even lines from the
   sync edges and darkens odd lines by the selected level. Dimmed and plain
   pixels leave with the same three cycle delay as the colour matrix */
`timescale 1ns/1ps
`default_nettype none

`include "analogizer_cfg.svh"

module scanline_dimmer
	import analogizer_pkg::*;
(
	input logic video_clk,
	input logic i_reset,
	input video_pix_t i_pix,
	input scanline_e i_level,
	output video_pix_t o_pix_dim,
	output video_pix_t o_pix_plain
);

	localparam int unsigned DEPTH = 3; // Matches ypbpr_matrix

	logic prev_hsync_n, prev_vsync_n; // Last input sample for edge detect
	logic odd_line;
	logic odd_nxt;
	logic hs_fall, vs_fall;
	video_pix_t pix_att;
	video_pix_t dim_q [DEPTH];
	video_pix_t plain_q [DEPTH];

	function automatic logic [`AZ_COLOR_W-1:0] attenuate(input logic [`AZ_COLOR_W-1:0] v,
			input scanline_e lvl);
		case (lvl)
			SL_25: attenuate = v - (v >> 2); // Keep 3/4
			SL_50: attenuate = v >> 1;
			SL_75: attenuate = v >> 2; // Keep 1/4
			default: attenuate = v; // SL_OFF
		endcase
	endfunction

	assign hs_fall = prev_hsync_n & ~i_pix.hsync_n;
	assign vs_fall = prev_vsync_n & ~i_pix.vsync_n;

	always_comb begin
		// Frame start wins over line toggle
		if (vs_fall) begin
			odd_nxt = 1'b0;
		end else if (hs_fall) begin
			odd_nxt = ~odd_line;
		end else begin
			odd_nxt = odd_line;
		end
		pix_att = i_pix;
		if (odd_nxt) begin // Edge pixel already sees the new line
			pix_att.r = attenuate(i_pix.r, i_level);
			pix_att.g = attenuate(i_pix.g, i_level);
			pix_att.b = attenuate(i_pix.b, i_level);
		end
	end

	always_ff @(posedge video_clk) begin
		if (i_reset) begin
			prev_hsync_n <= 1'b0; // No false edge on the first sample
			prev_vsync_n <= 1'b0;
			odd_line <= 1'b0;
			dim_q <= '{default: '0};
			plain_q <= '{default: '0};
		end else begin
			prev_hsync_n <= i_pix.hsync_n;
			prev_vsync_n <= i_pix.vsync_n;
			odd_line <= odd_nxt;
			dim_q[0] <= pix_att;
			plain_q[0] <= i_pix;
			for (int i = 1; i < DEPTH; i++) begin
				dim_q[i] <= dim_q[i-1];
				plain_q[i] <= plain_q[i-1];
			end
		end
	end

	assign o_pix_dim = dim_q[DEPTH-1];
	assign o_pix_plain = plain_q[DEPTH-1];

endmodule

`default_nettype wire

// File: design/cart_port_map.sv
/* Output side of the adapter. Picks source pixel and sync routing per mode,
   truncates to the DAC width and registers one DAC word. Packs it onto the
   cartridge banks in connector order; banks float low as inputs when disabled */
`timescale 1ns/1ps
`default_nettype none

`include "analogizer_cfg.svh"

module cart_port_map
	import analogizer_pkg::*;
(
	input logic video_clk,
	input logic i_reset,
	input logic i_ena,
	input video_mode_e i_mode,
	input video_pix_t i_pix_plain,
	input video_pix_t i_pix_dim,
	input video_pix_t i_pix_ypbpr,
	output logic [7:0] o_bank1,
	output logic [7:0] o_bank2,
	output logic [7:0] o_bank3,
	output logic o_bank1_dir,
	output logic o_bank2_dir,
	output logic o_bank3_dir
);

	dac_word_t dac_nxt;
	dac_word_t dac_q;
	logic port_off;
	logic [7:0] bank1_w, bank2_w, bank3_w;

	// DAC keeps the top bits only
	function automatic logic [`AZ_DAC_W-1:0] top_bits(input logic [`AZ_COLOR_W-1:0] c);
		top_bits = c[`AZ_COLOR_W-1 -: `AZ_DAC_W];
	endfunction

	always_comb begin
		case (i_mode)
			MODE_RGBS: begin
				dac_nxt.r = top_bits(i_pix_plain.r);
				dac_nxt.g = top_bits(i_pix_plain.g);
				dac_nxt.b = top_bits(i_pix_plain.b);
				dac_nxt.hs_pin = i_pix_plain.csync_n; // Csync to the H pin
				dac_nxt.vs_pin = 1'b1;
				dac_nxt.blank_n_pin = i_pix_plain.blank_n;
			end
			MODE_RGSB: begin
				dac_nxt.r = top_bits(i_pix_plain.r);
				dac_nxt.g = top_bits(i_pix_plain.g);
				dac_nxt.b = top_bits(i_pix_plain.b);
				dac_nxt.hs_pin = 1'b1;
				dac_nxt.vs_pin = i_pix_plain.csync_n; // DAC sync, SOG switch on
				dac_nxt.blank_n_pin = i_pix_plain.blank_n;
			end
			MODE_YPBPR: begin
				dac_nxt.r = top_bits(i_pix_ypbpr.r); // Pr
				dac_nxt.g = top_bits(i_pix_ypbpr.g); // Y
				dac_nxt.b = top_bits(i_pix_ypbpr.b); // Pb
				dac_nxt.hs_pin = 1'b1;
				dac_nxt.vs_pin = i_pix_ypbpr.csync_n;
				dac_nxt.blank_n_pin = 1'b1; // DAC blank would clip the sync tip
			end
			MODE_RGBHV_SL: begin
				dac_nxt.r = top_bits(i_pix_dim.r);
				dac_nxt.g = top_bits(i_pix_dim.g);
				dac_nxt.b = top_bits(i_pix_dim.b);
				dac_nxt.hs_pin = i_pix_dim.hsync_n;
				dac_nxt.vs_pin = i_pix_dim.vsync_n;
				dac_nxt.blank_n_pin = 1'b1;
			end
			default: begin
				// Unknown code, black with raw hsync
				dac_nxt.r = '0;
				dac_nxt.g = '0;
				dac_nxt.b = '0;
				dac_nxt.hs_pin = i_pix_plain.hsync_n;
				dac_nxt.vs_pin = 1'b1;
				dac_nxt.blank_n_pin = i_pix_plain.blank_n;
			end
		endcase
	end

	always_ff @(posedge video_clk) begin
		if (i_reset) begin
			dac_q <= '0;
		end else begin
			dac_q <= dac_nxt;
		end
	end

	// Connector order, MSB first
	assign bank3_w = {dac_q.r, dac_q.hs_pin, dac_q.vs_pin};
	assign bank2_w = {dac_q.b[0], dac_q.blank_n_pin, dac_q.g};
	assign bank1_w = {2'b00, video_clk, dac_q.b[`AZ_DAC_W-1:1]}; // DAC clock on bit 5

	assign port_off = i_reset | ~i_ena;

	// Disabled port is driven low and turned to input
	assign o_bank3 = port_off ? 8'h00 : bank3_w;
	assign o_bank2 = port_off ? 8'h00 : bank2_w;
	assign o_bank1 = port_off ? 8'h00 : bank1_w;
	assign o_bank3_dir = ~port_off;
	assign o_bank2_dir = ~port_off;
	assign o_bank1_dir = ~port_off;

endmodule

`default_nettype wire

// File: design/analogizer_video_top.sv
/* Video half of the analog adapter. Core RGB and syncs in, cartridge banks out.
   Banks show an input pixel five video_clk cycles after it is sampled */
`timescale 1ns/1ps
`default_nettype none

`include "analogizer_cfg.svh"

module analogizer_video_top
	import analogizer_pkg::*;
(
	input logic video_clk,
	input logic i_reset,
	input logic i_ena, // Port enable from the core
	input video_mode_e i_mode,
	input scanline_e i_level,
	input logic [`AZ_COLOR_W-1:0] i_r,
	input logic [`AZ_COLOR_W-1:0] i_g,
	input logic [`AZ_COLOR_W-1:0] i_b,
	input logic i_hsync_n,
	input logic i_vsync_n,
	input logic i_csync_n,
	input logic i_blank_n,
	output logic [7:0] o_bank1,
	output logic [7:0] o_bank2,
	output logic [7:0] o_bank3,
	output logic o_bank1_dir,
	output logic o_bank2_dir,
	output logic o_bank3_dir
);

	video_pix_t pix_in; // Blanked input pixel
	video_pix_t pix_ypbpr;
	video_pix_t pix_dim;
	video_pix_t pix_plain;

	video_in_stage u_video_in_stage (
		.i_reset(i_reset),
		.video_clk(video_clk),
		.i_r(i_r),
		.i_g(i_g),
		.i_b(i_b),
		.i_hsync_n(i_hsync_n),
		.i_vsync_n(i_vsync_n),
		.i_csync_n(i_csync_n),
		.i_blank_n(i_blank_n),
		.o_pix(pix_in)
	);

	ypbpr_matrix u_ypbpr_matrix (
		.video_clk(video_clk),
		.i_reset(i_reset),
		.i_pix(pix_in),
		.o_pix(pix_ypbpr)
	);

	scanline_dimmer u_scanline_dimmer (
		.video_clk(video_clk),
		.i_reset(i_reset),
		.i_pix(pix_in),
		.i_level(i_level),
		.o_pix_dim(pix_dim),
		.o_pix_plain(pix_plain)
	);

	cart_port_map u_cart_port_map (
		.video_clk(video_clk),
		.i_reset(i_reset),
		.i_ena(i_ena),
		.i_mode(i_mode),
		.i_pix_plain(pix_plain),
		.i_pix_dim(pix_dim),
		.i_pix_ypbpr(pix_ypbpr),
		.o_bank1(o_bank1),
		.o_bank2(o_bank2),
		.o_bank3(o_bank3),
		.o_bank1_dir(o_bank1_dir),
		.o_bank2_dir(o_bank2_dir),
		.o_bank3_dir(o_bank3_dir)
	);

endmodule

`default_nettype wire

// File: sim/tb_analogizer.sv
/* Testbench for the analog video adapter top level. Streams a table of pixels
   through every output mode and checks the cartridge banks five clocks later
   against values worked out from the mode, matrix and scanline rules */
`timescale 1ns/1ps
`default_nettype none

`include "analogizer_cfg.svh"

module tb_analogizer
	import analogizer_pkg::*;
();

	localparam real CLK_PERIOD = 40.0;
	localparam int LAT = `AZ_PIPE_LAT;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_ROWS = 128;
	localparam int WATCHDOG_CYCLES = MAX_ROWS * LAT + RESET_CYCLES + 200;
	localparam logic [31:0] LFSR_SEED = 32'hf807_44c3;
	localparam logic [31:0] LFSR_TAPS = 32'hb4bc_d35c; // Maximal length Galois mask

	// One table row of stimulus and expected pins
	typedef struct packed {
		logic [2:0] test;
		logic [3:0] mode;
		logic [1:0] level;
		logic [7:0] r, g, b;
		logic hsync_n, vsync_n, csync_n, blank_n;
		logic [7:0] exp_bank3, exp_bank2;
		logic [5:0] exp_bank1; // Bit 5 is video_clk which is high at the sample point
	} vec_t;

	typedef struct packed {
		logic chk; // Flush pixels are not checked
		logic [7:0] bank3, bank2;
		logic [5:0] bank1;
	} pend_t;

	logic video_clk = 1'b0;
	logic i_reset, i_ena;
	video_mode_e i_mode;
	scanline_e i_level;
	logic [7:0] i_r, i_g, i_b;
	logic i_hsync_n, i_vsync_n, i_csync_n, i_blank_n;
	logic [7:0] o_bank1, o_bank2, o_bank3;
	logic o_bank1_dir, o_bank2_dir, o_bank3_dir;

	vec_t vec_tab [MAX_ROWS];
	int n_rows = 0;
	pend_t pend_q [$]; // Pixels in flight with the oldest first
	logic [31:0] lfsr = LFSR_SEED;
	logic model_hs = 1'b1; // Line parity model starting from idle high syncs
	logic model_vs = 1'b1;
	logic model_odd = 1'b0;
	int errs_by_test [1:6];
	int total_errs = 0;
	int total_checks = 0;
	int tests_failed = 0;
	int cur_test = 1;

	always #(CLK_PERIOD / 2) video_clk = ~video_clk;

	analogizer_video_top u_analogizer_video_top (
		.video_clk(video_clk), .i_reset(i_reset), .i_ena(i_ena),
		.i_mode(i_mode), .i_level(i_level),
		.i_r(i_r), .i_g(i_g), .i_b(i_b),
		.i_hsync_n(i_hsync_n), .i_vsync_n(i_vsync_n),
		.i_csync_n(i_csync_n), .i_blank_n(i_blank_n),
		.o_bank1(o_bank1), .o_bank2(o_bank2), .o_bank3(o_bank3),
		.o_bank1_dir(o_bank1_dir), .o_bank2_dir(o_bank2_dir), .o_bank3_dir(o_bank3_dir)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_byte(output logic [7:0] v);
		for (int i = 0; i < 8; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [7:0] clip_byte(input int v);
		if (v < 0) begin
			clip_byte = 8'd0;
		end else if (v > 255) begin
			clip_byte = 8'd255;
		end else begin
			clip_byte = v[7:0];
		end
	endfunction

	// Odd line colour by integer division
	function automatic logic [7:0] dim_byte(input logic [7:0] v, input logic [1:0] lvl);
		case (lvl)
			2'd1: dim_byte = v - v / 4;
			2'd2: dim_byte = v / 2;
			2'd3: dim_byte = v / 4;
			default: dim_byte = v;
		endcase
	endfunction

	// Top six bits per colour packed as {bank3, bank2, bank1[5:0]}
	function automatic logic [21:0] pack_banks(input logic [7:0] r, g, b,
			input logic hs, vs, bl);
		logic [7:0] b3, b2;
		logic [5:0] b1;
		b3 = {r[7:2], hs, vs};
		b2 = {b[2], bl, g[7:2]}; // DAC B[0] leads bank2
		b1 = {1'b1, b[7:3]};
		pack_banks = {b3, b2, b1};
	endfunction

	task automatic add_row(input logic [2:0] test, input logic [3:0] mode,
			input logic [1:0] level, input logic [7:0] r, g, b, input logic hs, vs, cs, bl);
		vec_t v;
		logic [7:0] rm, gm, bm;
		int ri, gi, bi, y, pb, pr;
		logic [21:0] banks;
		if (vs == 1'b0 && model_vs == 1'b1) begin
			model_odd = 1'b0; // Frame start gives an even line
		end else if (hs == 1'b0 && model_hs == 1'b1) begin
			model_odd = ~model_odd;
		end
		model_hs = hs;
		model_vs = vs;
		rm = bl ? r : 8'd0; // Black during blanking
		gm = bl ? g : 8'd0;
		bm = bl ? b : 8'd0;
		ri = rm;
		gi = gm;
		bi = bm;
		case (mode)
			MODE_RGBS: banks = pack_banks(rm, gm, bm, cs, 1'b1, bl);
			MODE_RGSB: banks = pack_banks(rm, gm, bm, 1'b1, cs, bl);
			MODE_YPBPR: begin
				y = (`AZ_Y_KR * ri + `AZ_Y_KG * gi + `AZ_Y_KB * bi) >>> 8;
				pb = ((`AZ_PB_KR * ri + `AZ_PB_KG * gi + `AZ_PB_KB * bi) >>> 8) + 128;
				pr = ((`AZ_PR_KR * ri + `AZ_PR_KG * gi + `AZ_PR_KB * bi) >>> 8) + 128;
				banks = pack_banks(clip_byte(pr), y[7:0], clip_byte(pb), 1'b1, cs, 1'b1);
			end
			MODE_RGBHV_SL: begin
				if (model_odd) begin
					rm = dim_byte(rm, level);
					gm = dim_byte(gm, level);
					bm = dim_byte(bm, level);
				end
				banks = pack_banks(rm, gm, bm, hs, vs, 1'b1);
			end
			default: banks = pack_banks(8'd0, 8'd0, 8'd0, hs, 1'b1, bl);
		endcase
		v = {test, mode, level, r, g, b, hs, vs, cs, bl, banks};
		if (n_rows < MAX_ROWS) begin
			vec_tab[n_rows] = v;
			n_rows++;
		end else begin
			$display("vector table is full, a row was dropped");
			total_errs++;
		end
	endtask

	task automatic build_table();
		logic [7:0] r, g, b;
		logic [9:0] hs_pat, vs_pat;
		logic [3:0] odd_codes [4];
		hs_pat = 10'b10_0101_1010; // Line sequence with bit i for row i
		vs_pat = 10'b11_1111_1110;
		odd_codes = '{4'd3, 4'd4, 4'd7, 4'd15};
		// RGBS then RGsB
		for (int m = 0; m < 2; m++) begin
			add_row(3'd2, m, 2'd0, 8'hff, 8'hff, 8'hff, 1'b1, 1'b1, 1'b1, 1'b1);
			add_row(3'd2, m, 2'd0, 8'h12, 8'hab, 8'hfc, 1'b1, 1'b1, 1'b0, 1'b1);
			add_row(3'd2, m, 2'd0, 8'hff, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0, 1'b0);
			for (int i = 0; i < 4; i++) begin
				draw_byte(r);
				draw_byte(g);
				draw_byte(b);
				add_row(3'd2, m, 2'd0, r, g, b, 1'b1, 1'b1, i[0], i != 3);
			end
		end
		// YPbPr with fixed colours first
		add_row(3'd3, MODE_YPBPR, 2'd0, 8'hff, 8'hff, 8'hff, 1'b1, 1'b1, 1'b1, 1'b1);
		add_row(3'd3, MODE_YPBPR, 2'd0, 8'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0, 1'b1);
		add_row(3'd3, MODE_YPBPR, 2'd0, 8'hff, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1);
		add_row(3'd3, MODE_YPBPR, 2'd0, 8'h00, 8'hff, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1);
		add_row(3'd3, MODE_YPBPR, 2'd0, 8'h00, 8'h00, 8'hff, 1'b1, 1'b1, 1'b0, 1'b1);
		add_row(3'd3, MODE_YPBPR, 2'd0, 8'h80, 8'h40, 8'hc0, 1'b1, 1'b1, 1'b1, 1'b0);
		for (int i = 0; i < 8; i++) begin
			draw_byte(r);
			draw_byte(g);
			draw_byte(b);
			add_row(3'd3, MODE_YPBPR, 2'd0, r, g, b, 1'b1, 1'b1, i[0], 1'b1);
		end
		// Scanlines with the same line sequence at every level
		for (int lvl = 0; lvl < 4; lvl++) begin
			for (int i = 0; i < 10; i++) begin
				draw_byte(r);
				draw_byte(g);
				draw_byte(b);
				add_row(3'd4, MODE_RGBHV_SL, lvl, r, g, b, hs_pat[i], vs_pat[i],
					hs_pat[i] & vs_pat[i], 1'b1);
			end
		end
		// Codes with no mode behind them
		for (int c = 0; c < 4; c++) begin
			draw_byte(r);
			draw_byte(g);
			draw_byte(b);
			add_row(3'd5, odd_codes[c], 2'd0, r, g, b, c[0], 1'b1, 1'b0, 1'b1);
			// Low vsync here while the V pin stays high
			add_row(3'd5, odd_codes[c], 2'd0, g, b, r, ~c[0], 1'b0, 1'b1, 1'b0);
		end
		// Back to back distinct pixels
		for (int i = 0; i < 10; i++) begin
			draw_byte(r);
			draw_byte(b);
			add_row(3'd6, MODE_RGBS, 2'd0, r, 8'(i * 29), b, 1'b1, 1'b1, i[0], 1'b1);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		total_checks++;
		if (got !== exp) begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			total_errs++;
			errs_by_test[cur_test]++;
		end
	endtask

	// Sample 1 ns after the edge and drive 1 ns later
	task automatic tick();
		pend_t p;
		@(posedge video_clk);
		#1;
		if (pend_q.size() == LAT) begin
			p = pend_q.pop_front(); // Driven LAT edges ago
			if (p.chk) begin
				check_value("o_bank3", o_bank3, p.bank3);
				check_value("o_bank2", o_bank2, p.bank2);
				check_value("o_bank1[5:0]", o_bank1[5:0], p.bank1);
				check_value("o_bank1[7:6]", o_bank1[7:6], 2'b00); // Old SNAC bits
			end
		end
		#1;
	endtask

	task automatic apply_pixel(input vec_t v, input logic chk);
		pend_t p;
		tick();
		i_mode = video_mode_e'(v.mode);
		i_level = scanline_e'(v.level);
		i_r = v.r;
		i_g = v.g;
		i_b = v.b;
		i_hsync_n = v.hsync_n;
		i_vsync_n = v.vsync_n;
		i_csync_n = v.csync_n;
		i_blank_n = v.blank_n;
		p = {chk, v.exp_bank3, v.exp_bank2, v.exp_bank1};
		pend_q.push_back(p);
	endtask

	// Black pixels with syncs and mode held so line parity stays put
	task automatic flush_pipe(input vec_t last);
		vec_t f;
		f = last;
		f.r = 8'd0;
		f.g = 8'd0;
		f.b = 8'd0;
		repeat (LAT) apply_pixel(f, 1'b0);
	endtask

	task automatic check_port_off();
		check_value("o_bank1", o_bank1, 8'h00);
		check_value("o_bank2", o_bank2, 8'h00);
		check_value("o_bank3", o_bank3, 8'h00);
		check_value("o_bank1_dir", o_bank1_dir, 1'b0);
		check_value("o_bank2_dir", o_bank2_dir, 1'b0);
		check_value("o_bank3_dir", o_bank3_dir, 1'b0);
	endtask

	function automatic string test_name(input int t);
		case (t)
			1: test_name = "reset and port enable";
			2: test_name = "RGBS and RGsB packing";
			3: test_name = "YPbPr matrix";
			4: test_name = "RGBHV scanlines";
			5: test_name = "undefined mode codes";
			default: test_name = "back to back pixels";
		endcase
	endfunction

	task automatic report_test(input int t);
		if (errs_by_test[t] == 0) begin
			$display("test %0d %s: pass", t, test_name(t));
		end else begin
			$display("test %0d %s: %0d mismatches", t, test_name(t), errs_by_test[t]);
			tests_failed++;
		end
	endtask

	initial begin
		i_reset = 1'b1;
		i_ena = 1'b0;
		i_mode = MODE_RGBS;
		i_level = SL_OFF;
		i_r = 8'd0;
		i_g = 8'd0;
		i_b = 8'd0;
		i_hsync_n = 1'b1;
		i_vsync_n = 1'b1;
		i_csync_n = 1'b1;
		i_blank_n = 1'b1;
		build_table();
		// Port gated in reset and while disabled
		repeat (RESET_CYCLES) begin
			tick();
			check_port_off();
		end
		i_reset = 1'b0;
		repeat (4) begin
			tick();
			check_port_off();
		end
		i_ena = 1'b1;
		tick();
		check_value("o_bank1_dir", o_bank1_dir, 1'b1);
		check_value("o_bank2_dir", o_bank2_dir, 1'b1);
		check_value("o_bank3_dir", o_bank3_dir, 1'b1);
		report_test(1);
		for (int i = 0; i < n_rows; i++) begin
			if (i > 0 && vec_tab[i].test != vec_tab[i-1].test) begin
				flush_pipe(vec_tab[i-1]);
				report_test(vec_tab[i-1].test);
			end else if (i > 0 && (vec_tab[i].mode != vec_tab[i-1].mode ||
					vec_tab[i].level != vec_tab[i-1].level)) begin
				flush_pipe(vec_tab[i-1]); // Mode acts at once so drain first
			end
			cur_test = vec_tab[i].test;
			apply_pixel(vec_tab[i], 1'b1);
		end
		flush_pipe(vec_tab[n_rows-1]);
		report_test(vec_tab[n_rows-1].test);
		$display("summary: 6 tests, %0d failed, %0d checks, %0d mismatches",
			tests_failed, total_checks, total_errs);
		if (total_errs == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Upper bound on run length from table rows plus reset plus slack
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run still going after %0d clock cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
design/analogizer_pkg.sv
design/video_in_stage.sv
design/ypbpr_matrix.sv
design/scanline_dimmer.sv
design/cart_port_map.sv
design/analogizer_video_top.sv
sim/tb_analogizer.sv

// File: Bender.yml
package:
  name: analogizer_video

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/analogizer_pkg.sv
      - design/video_in_stage.sv
      - design/ypbpr_matrix.sv
      - design/scanline_dimmer.sv
      - design/cart_port_map.sv
      - design/analogizer_video_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_analogizer.sv
